// File: bench/tb_ltssm_config.sv
/* Acts as the link partner and sink of the config controller.
   Ready comes from an LFSR in the back-pressure tests and is held high otherwise. */
module tb_ltssm_config;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [1:0] SET_PAD_TS1  = 2'd0;
  localparam logic [1:0] SET_LANE_TS1 = 2'd1;
  localparam logic [1:0] SET_TS2      = 2'd2;
  localparam logic [1:0] SET_IDLE     = 2'd3;
  // worst case for one set under random ready
  localparam int SET_BUDGET = ltssm_cfg_pkg::BEATS_PER_OS * 16 + 2;
  localparam int RUN_BUDGET = (ltssm_cfg_pkg::IDLE_MIN_RECEIVED + 8) * SET_BUDGET;
  localparam int WATCHDOG_CYCLES = 3 * RUN_BUDGET + ltssm_cfg_pkg::TIMEOUT_LONG_CYCLES +
    ltssm_cfg_pkg::TIMEOUT_SHORT_CYCLES + 8 * SET_BUDGET + 100;
  localparam ltssm_cfg_pkg::beat_idx_t LAST_BEAT =
    ltssm_cfg_pkg::beat_idx_t'(ltssm_cfg_pkg::BEATS_PER_OS - 1);

  logic                        clk_i = 1'b0;
  logic                        rst_i = 1'b1;
  logic                        en_i = 1'b0;
  ltssm_cfg_pkg::lane_status_t lane_status_i = '0;
  logic                        m_ready_i = 1'b0;
  logic                        m_valid_o;
  ltssm_cfg_pkg::stream_beat_t m_beat_o;
  logic                        success_o;
  logic                        error_o;

  logic                        rand_ready = 1'b0;
  logic [15:0]                 lfsr_state = 16'd1272;
  int                          cycle_cnt = 0;
  int                          errors = 0;
  int                          errors_at_start = 0;
  int                          n_tests = 0;
  int                          n_passed = 0;
  int                          n_sets [4];
  int                          n_stalls = 0;
  int                          set_start = 0;
  int                          set_end = 0;
  int                          ts2_start = 0;
  string                       cur_test = "startup";
  logic [1:0]                  last_code = SET_PAD_TS1;
  ltssm_cfg_pkg::beat_idx_t    beat_n = '0;
  ltssm_cfg_pkg::os_words_t    got_words;

  ltssm_config_top dut_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .en_i          (en_i),
    .lane_status_i (lane_status_i),
    .m_ready_i     (m_ready_i),
    .m_valid_o     (m_valid_o),
    .m_beat_o      (m_beat_o),
    .success_o     (success_o),
    .error_o       (error_o)
  );

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // taps 16,14,13,11
  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  always @(posedge clk_i) begin
    #1;
    if (rand_ready) begin
      lfsr_state = lfsr_step(lfsr_state);
      m_ready_i  = lfsr_state[0];
    end else begin
      m_ready_i = 1'b1;
    end
  end

  task automatic report_failure(string msg);
    errors++;
    $display("%s: %s", cur_test, msg);
  endtask

  task automatic check_eq(string what, int expected, int actual);
    assert (expected == actual) else begin
      errors++;
      $display("[ERROR] %s: %s expected %0h actual %0h", cur_test, what, expected, actual);
    end
  endtask

  // ordered-set rule written out per word, symbol 0 in the low byte
  function automatic ltssm_cfg_pkg::os_words_t expect_words(logic [1:0] code);
    ltssm_cfg_pkg::symbol_t   id;
    ltssm_cfg_pkg::symbol_t   lane;
    ltssm_cfg_pkg::os_words_t w;
    id   = (code == SET_TS2) ? ltssm_cfg_pkg::TS2_ID : ltssm_cfg_pkg::TS1_ID;
    lane = (code == SET_PAD_TS1) ? ltssm_cfg_pkg::PAD_SYMBOL : 8'h00;
    w[0] = {ltssm_cfg_pkg::N_FTS_DEFAULT, lane, ltssm_cfg_pkg::LINK_NUM,
            ltssm_cfg_pkg::COM_SYMBOL};
    w[1] = {id, id, 8'h00, ltssm_cfg_pkg::RATE_ID_DEFAULT};
    w[2] = {4{id}};
    w[3] = {4{id}};
    if (code == SET_IDLE) begin
      w = '0;
    end
    return w;
  endfunction

  task automatic check_set(ltssm_cfg_pkg::user_t user);
    logic [1:0]               code;
    ltssm_cfg_pkg::os_words_t exp;
    ltssm_cfg_pkg::user_t     exp_user;
    if (got_words[3][31:24] == ltssm_cfg_pkg::TS2_ID) begin
      code = SET_TS2;
    end else if (got_words[3][31:24] == ltssm_cfg_pkg::TS1_ID) begin
      code = (got_words[0][23:16] == ltssm_cfg_pkg::PAD_SYMBOL) ? SET_PAD_TS1 : SET_LANE_TS1;
    end else begin
      code = SET_IDLE;
    end
    exp      = expect_words(code);
    exp_user = (code == SET_PAD_TS1) ? ltssm_cfg_pkg::USER_LINK_WIDTH
                                     : ltssm_cfg_pkg::USER_LANE_NUM;
    for (int i = 0; i < ltssm_cfg_pkg::BEATS_PER_OS; i++) begin
      check_eq($sformatf("word %0d of set kind %0d", i, code),
               int'(exp[i[1:0]]), int'(got_words[i[1:0]]));
    end
    check_eq("user tag", int'(exp_user), int'(user));
    assert (code >= last_code) else begin
      report_failure($sformatf("set kind %0d sent after kind %0d", code, last_code));
    end
    if (code == SET_TS2 && n_sets[SET_TS2] == 0) begin
      ts2_start = set_start;
    end
    last_code     = code;
    n_sets[code] = n_sets[code] + 1;
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk_i) begin
    if (!rst_i && m_valid_o && !m_ready_i) begin
      n_stalls++;
    end
    if (!rst_i && m_valid_o && m_ready_i) begin
      if (beat_n == '0) begin
        set_start = cycle_cnt;
      end
      got_words[beat_n] = m_beat_o.data;
      assert (m_beat_o.last == (beat_n == LAST_BEAT)) else begin
        report_failure($sformatf("last flag wrong on beat %0d", beat_n));
      end
      if (beat_n == LAST_BEAT) begin
        set_end = cycle_cnt;
        check_set(m_beat_o.user);
      end
      beat_n = beat_n + 1'b1;
    end
  end

  assert property (@(posedge clk_i) disable iff (rst_i)
    (m_valid_o && !m_ready_i) |=> (m_valid_o && $stable(m_beat_o)))
    else report_failure("beat changed or valid dropped while the sink stalled");

  assert property (@(posedge clk_i) disable iff (rst_i)
    (m_valid_o && m_ready_i && m_beat_o.last) |=> !m_valid_o)
    else report_failure("no gap cycle after the last beat of a set");

  assert property (@(posedge clk_i) disable iff (rst_i) !(success_o && error_o))
    else report_failure("success and error are both high");

  task automatic start_test(string name);
    cur_test        = name;
    errors_at_start = errors;
    last_code       = SET_PAD_TS1;
    n_stalls        = 0;
    for (int i = 0; i < 4; i++) begin
      n_sets[i[1:0]] = 0;
    end
  endtask

  // drops enable, the flags must be gone one cycle later
  task automatic close_test();
    en_i          = 1'b0;
    lane_status_i = '0;
    @(negedge clk_i);
    @(negedge clk_i);
    check_eq("success_o after en_i low", 0, int'(success_o));
    check_eq("error_o after en_i low", 0, int'(error_o));
    check_eq("m_valid_o after en_i low", 0, int'(m_valid_o));
    n_tests++;
    if (errors == errors_at_start) begin
      n_passed++;
      $display("%s: PASS", cur_test);
    end else begin
      $display("%s: FAIL (%0d errors)", cur_test, errors - errors_at_start);
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic wait_sets(logic [1:0] code, int n);
    do @(posedge clk_i); while (n_sets[code] < n);
    #1;
  endtask

  task automatic wait_flag(output int at_cycle);
    do @(negedge clk_i); while (!success_o && !error_o);
    at_cycle = cycle_cnt;
    @(posedge clk_i);
    #1;
  endtask

  task automatic run_success(bit reconfig);
    int t_done;
    en_i = 1'b1;
    wait_sets(SET_PAD_TS1, 2);
    lane_status_i.link_width_satisfied = 4'b0001;
    lane_status_i.lanes_formed         = 1'b1;
    lane_status_i.complete_ts2         = '1;
    lane_status_i.single_idle_received = 1'b1;
    lane_status_i.idle_satisfied       = 1'b1;
    if (reconfig) begin
      lane_status_i.lane_reconfig = 1'b1;
      wait_sets(SET_LANE_TS1, 1);
      // released once the resent TS1 is on the wire
      do @(negedge clk_i); while (!m_valid_o);
      @(posedge clk_i);
      #1;
      lane_status_i.lane_reconfig = 1'b0;
    end
    lane_status_i.lane_nums_match = 1'b1;
    wait_flag(t_done);
    check_eq("success_o", 1, int'(success_o));
    check_eq("error_o", 0, int'(error_o));
    // done one cycle after the last beat, success one cycle after done
    check_eq("cycles from last idle beat to success_o", 2, t_done - set_end);
    check_eq("padded TS1 sets", 2, n_sets[SET_PAD_TS1]);
    check_eq("lane TS1 sets", reconfig ? 2 : 1, n_sets[SET_LANE_TS1]);
    check_eq("TS2 sets", 1, n_sets[SET_TS2]);
    // the counter is compared before the set in flight is counted
    check_eq("idle sets", ltssm_cfg_pkg::IDLE_MIN_RECEIVED + 1, n_sets[SET_IDLE]);
  endtask

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, a test never finished", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

  initial begin : main
    int t0;
    int t1;
    repeat (5) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    start_test("reset_quiet");
    repeat (8) begin
      @(negedge clk_i);
      check_eq("m_valid_o", 0, int'(m_valid_o));
      check_eq("success_o", 0, int'(success_o));
      check_eq("error_o", 0, int'(error_o));
    end
    @(posedge clk_i);
    #1;
    close_test();

    start_test("happy_path");
    run_success(1'b0);
    close_test();

    start_test("width_timeout");
    rand_ready = 1'b1;
    en_i       = 1'b1;
    t0         = cycle_cnt;
    wait_flag(t1);
    check_eq("error_o", 1, int'(error_o));
    check_eq("success_o", 0, int'(success_o));
    check_eq("TS2 sets", 0, n_sets[SET_TS2]);
    check_eq("lane TS1 sets", 0, n_sets[SET_LANE_TS1]);
    assert (t1 - t0 >= ltssm_cfg_pkg::TIMEOUT_LONG_CYCLES &&
            t1 - t0 <= ltssm_cfg_pkg::TIMEOUT_LONG_CYCLES + SET_BUDGET) else begin
      report_failure($sformatf("error raised %0d cycles after enable", t1 - t0));
    end
    close_test();

    start_test("lane_reconfig");
    run_success(1'b1);
    close_test();

    start_test("backpressure");
    run_success(1'b0);
    assert (n_stalls > 0) else begin
      report_failure("the sink never stalled the stream");
    end
    close_test();

    start_test("complete_timeout");
    rand_ready                         = 1'b0;
    lane_status_i.link_width_satisfied = 4'b0011;
    lane_status_i.lanes_formed         = 1'b1;
    lane_status_i.lane_nums_match      = 1'b1;
    lane_status_i.complete_ts2         = 4'b0111;
    en_i                               = 1'b1;
    wait_flag(t1);
    check_eq("error_o", 1, int'(error_o));
    check_eq("success_o", 0, int'(success_o));
    check_eq("idle sets", 0, n_sets[SET_IDLE]);
    assert (n_sets[SET_TS2] > 0 &&
            t1 - ts2_start >= ltssm_cfg_pkg::TIMEOUT_SHORT_CYCLES &&
            t1 - ts2_start <= ltssm_cfg_pkg::TIMEOUT_SHORT_CYCLES + SET_BUDGET) else begin
      report_failure($sformatf("error raised %0d cycles after the first TS2", t1 - ts2_start));
    end
    close_test();

    $display("tests: %0d run, %0d passed, %0d failed, %0d failed checks",
             n_tests, n_passed, n_tests - n_passed, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: compile.f
verilog/ltssm_cfg_pkg.sv
verilog/config_timer.sv
verilog/os_builder.sv
verilog/os_serializer.sv
verilog/config_fsm.sv
verilog/ltssm_config_top.sv
bench/tb_ltssm_config.sv

// File: run.sh
#!/bin/sh
# builds and runs the testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_ltssm_config -f compile.f -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -q "Test passed"

// File: verilog/config_fsm.sv
/* os_start is only raised while the serializer is idle: in idle or on os_done.
   Success and error are sticky until en_i falls. */
module config_fsm (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        en_i,
  input  ltssm_cfg_pkg::lane_status_t lane_status_i,
  input  logic                        os_done_i,
  input  logic                        timer_expired_i,
  output logic                        os_start_o,
  output ltssm_cfg_pkg::os_request_t  os_request_o,
  output logic                        timer_restart_o,
  output logic                        timer_long_o,
  output logic                        success_o,
  output logic                        error_o
);

  ltssm_cfg_pkg::cfg_state_e state_q, state_d;
  ltssm_cfg_pkg::idle_cnt_t  idle_cnt_q, idle_cnt_d;
  logic                      success_d;
  logic                      error_d;
  logic                      idle_cnt_full;

  function automatic ltssm_cfg_pkg::os_request_t make_req(
    ltssm_cfg_pkg::os_kind_e kind,
    logic                    pad,
    ltssm_cfg_pkg::user_t    user
  );
    ltssm_cfg_pkg::os_request_t req;
    req.kind     = kind;
    req.lane_pad = pad;
    req.user     = user;
    return req;
  endfunction

  assign idle_cnt_full =
    (idle_cnt_q == ltssm_cfg_pkg::idle_cnt_t'(ltssm_cfg_pkg::IDLE_MIN_RECEIVED));

  always_comb begin
    state_d         = state_q;
    idle_cnt_d      = idle_cnt_q;
    success_d       = success_o;
    error_d         = error_o;
    os_start_o      = 1'b0;
    timer_restart_o = 1'b0;
    timer_long_o    = 1'b0;
    os_request_o    = make_req(ltssm_cfg_pkg::OS_TS1, 1'b1, ltssm_cfg_pkg::USER_LINK_WIDTH);

    case (state_q)
      ltssm_cfg_pkg::ST_IDLE: begin
        if (en_i) begin
          os_start_o      = 1'b1;
          timer_restart_o = 1'b1;
          timer_long_o    = 1'b1;
          state_d         = ltssm_cfg_pkg::ST_LINK_WIDTH;
        end
      end
      ltssm_cfg_pkg::ST_LINK_WIDTH: begin
        // padded TS1s until some lane has the width it wants
        if (os_done_i) begin
          if (|lane_status_i.link_width_satisfied) begin
            timer_restart_o = 1'b1;
            state_d         = ltssm_cfg_pkg::ST_WIDTH_ACCEPT;
          end else if (timer_expired_i) begin
            error_d = 1'b1;
            state_d = ltssm_cfg_pkg::ST_WAIT_EN_LOW;
          end else begin
            os_start_o = 1'b1;
          end
        end
      end
      ltssm_cfg_pkg::ST_WIDTH_ACCEPT: begin
        if (lane_status_i.lanes_formed) begin
          os_start_o   = 1'b1;
          os_request_o = make_req(ltssm_cfg_pkg::OS_TS1, 1'b0, ltssm_cfg_pkg::USER_LANE_NUM);
          state_d      = ltssm_cfg_pkg::ST_LANE_TS1;
        end else if (timer_expired_i) begin
          error_d = 1'b1;
          state_d = ltssm_cfg_pkg::ST_WAIT_EN_LOW;
        end
      end
      ltssm_cfg_pkg::ST_LANE_TS1: begin
        if (os_done_i) begin
          state_d = ltssm_cfg_pkg::ST_LANE_ACCEPT;
        end
      end
      ltssm_cfg_pkg::ST_LANE_ACCEPT: begin
        // no timeout here
        if (lane_status_i.lane_nums_match) begin
          os_start_o      = 1'b1;
          timer_restart_o = 1'b1;
          os_request_o    = make_req(ltssm_cfg_pkg::OS_TS2, 1'b0, ltssm_cfg_pkg::USER_LANE_NUM);
          state_d         = ltssm_cfg_pkg::ST_COMPLETE;
        end else if (lane_status_i.lane_reconfig) begin
          os_start_o   = 1'b1;
          os_request_o = make_req(ltssm_cfg_pkg::OS_TS1, 1'b0, ltssm_cfg_pkg::USER_LANE_NUM);
          state_d      = ltssm_cfg_pkg::ST_LANE_TS1;
        end
      end
      ltssm_cfg_pkg::ST_COMPLETE: begin
        if (os_done_i) begin
          if (&lane_status_i.complete_ts2) begin
            os_start_o   = 1'b1;
            os_request_o = make_req(ltssm_cfg_pkg::OS_IDLE, 1'b0, ltssm_cfg_pkg::USER_LANE_NUM);
            idle_cnt_d   = '0;
            state_d      = ltssm_cfg_pkg::ST_CFG_IDLE;
          end else if (timer_expired_i) begin
            error_d = 1'b1;
            state_d = ltssm_cfg_pkg::ST_WAIT_EN_LOW;
          end else begin
            os_start_o   = 1'b1;
            os_request_o = make_req(ltssm_cfg_pkg::OS_TS2, 1'b0, ltssm_cfg_pkg::USER_LANE_NUM);
          end
        end
      end
      ltssm_cfg_pkg::ST_CFG_IDLE: begin
        if (os_done_i) begin
          if (lane_status_i.single_idle_received && !idle_cnt_full) begin
            idle_cnt_d = idle_cnt_q + 1'b1;
          end
          // decision uses the count before this set
          if (lane_status_i.idle_satisfied && idle_cnt_full) begin
            success_d = 1'b1;
            state_d   = ltssm_cfg_pkg::ST_WAIT_EN_LOW;
          end else begin
            os_start_o   = 1'b1;
            os_request_o = make_req(ltssm_cfg_pkg::OS_IDLE, 1'b0, ltssm_cfg_pkg::USER_LANE_NUM);
          end
        end
      end
      ltssm_cfg_pkg::ST_WAIT_EN_LOW: begin
        if (!en_i) begin
          success_d = 1'b0;
          error_d   = 1'b0;
          state_d   = ltssm_cfg_pkg::ST_IDLE;
        end
      end
      default: begin
        state_d = ltssm_cfg_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q    <= ltssm_cfg_pkg::ST_IDLE;
      idle_cnt_q <= '0;
      success_o  <= 1'b0;
      error_o    <= 1'b0;
    end else begin
      state_q    <= state_d;
      idle_cnt_q <= idle_cnt_d;
      success_o  <= success_d;
      error_o    <= error_d;
    end
  end

endmodule

// File: verilog/config_timer.sv
/* expired_o rises exactly the selected number of cycles after restart_i
   and stays high until the next restart; it is low before the first one. */
module config_timer (
  input  logic clk_i,
  input  logic rst_i,
  input  logic restart_i,
  input  logic long_i,
  output logic expired_o
);

  ltssm_cfg_pkg::timer_t count_q;
  ltssm_cfg_pkg::timer_t limit_q;
  logic                  armed_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      count_q <= '0;
      limit_q <= '0;
      armed_q <= 1'b0;
    end else if (restart_i) begin
      // restart cycle counts as the first
      count_q <= ltssm_cfg_pkg::timer_t'(1);
      limit_q <= long_i ? ltssm_cfg_pkg::timer_t'(ltssm_cfg_pkg::TIMEOUT_LONG_CYCLES)
                        : ltssm_cfg_pkg::timer_t'(ltssm_cfg_pkg::TIMEOUT_SHORT_CYCLES);
      armed_q <= 1'b1;
    end else if (armed_q && count_q != limit_q) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign expired_o = armed_q && (count_q == limit_q);

endmodule

// File: verilog/ltssm_cfg_pkg.sv
/* Shared widths, symbols and types for the downstream-port config controller.
   Timeouts are sized for simulation and are far shorter than the PCIe values. */
package ltssm_cfg_pkg;

  localparam int NUM_LANES    = 4;
  localparam int WORD_BITS    = 32;
  localparam int USER_BITS    = 8;
  localparam int BEATS_PER_OS = 4;
  localparam int SYMS_PER_OS  = 16;

  typedef logic [NUM_LANES-1:0] lane_mask_t;
  typedef logic [WORD_BITS-1:0] word_t;
  typedef logic [7:0]           symbol_t;
  typedef logic [USER_BITS-1:0] user_t;
  typedef logic [1:0]           beat_idx_t;

  // ordered-set symbols
  localparam symbol_t COM_SYMBOL      = 8'hBC;
  localparam symbol_t PAD_SYMBOL      = 8'hF7;
  localparam symbol_t TS1_ID          = 8'h4A;
  localparam symbol_t TS2_ID          = 8'h45;
  localparam symbol_t N_FTS_DEFAULT   = 8'h10;
  localparam symbol_t RATE_ID_DEFAULT = 8'h02;
  localparam symbol_t LINK_NUM        = 8'h00;

  // side-band tags on the stream
  localparam user_t USER_LINK_WIDTH = 8'h01;
  localparam user_t USER_LANE_NUM   = 8'h03;

  localparam int TIMEOUT_LONG_CYCLES  = 300;
  localparam int TIMEOUT_SHORT_CYCLES = 40;
  typedef logic [15:0] timer_t;

  localparam int IDLE_MIN_RECEIVED = 16;
  typedef logic [4:0] idle_cnt_t;

  typedef enum logic [1:0] {
    OS_TS1,
    OS_TS2,
    OS_IDLE
  } os_kind_e;

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_LINK_WIDTH,
    ST_WIDTH_ACCEPT,
    ST_LANE_TS1,
    ST_LANE_ACCEPT,
    ST_COMPLETE,
    ST_CFG_IDLE,
    ST_WAIT_EN_LOW
  } cfg_state_e;

  // per-link status reported by the receive side
  typedef struct packed {
    lane_mask_t link_width_satisfied;
    logic       lanes_formed;
    logic       lane_nums_match;
    logic       lane_reconfig;
    lane_mask_t complete_ts2;
    logic       single_idle_received;
    logic       idle_satisfied;
  } lane_status_t;

  typedef struct packed {
    os_kind_e kind;
    logic     lane_pad;
    user_t    user;
  } os_request_t;

  // word 0 sits in the low bits
  typedef word_t [BEATS_PER_OS-1:0] os_words_t;

  typedef struct packed {
    word_t data;
    user_t user;
    logic  last;
  } stream_beat_t;

endpackage

// File: verilog/ltssm_config_top.sv
/* Downstream port only; the output stream has no keep, every byte is valid.
   The lane-number wait has no timeout. */
module ltssm_config_top (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        en_i,
  input  ltssm_cfg_pkg::lane_status_t lane_status_i,
  input  logic                        m_ready_i,
  output logic                        m_valid_o,
  output ltssm_cfg_pkg::stream_beat_t m_beat_o,
  output logic                        success_o,
  output logic                        error_o
);

  ltssm_cfg_pkg::os_request_t os_req;
  ltssm_cfg_pkg::os_words_t   os_words;
  logic                       os_start;
  logic                       os_done;
  logic                       timer_restart;
  logic                       timer_long;
  logic                       timer_expired;

  config_fsm fsm_i (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .en_i            (en_i),
    .lane_status_i   (lane_status_i),
    .os_done_i       (os_done),
    .timer_expired_i (timer_expired),
    .os_start_o      (os_start),
    .os_request_o    (os_req),
    .timer_restart_o (timer_restart),
    .timer_long_o    (timer_long),
    .success_o       (success_o),
    .error_o         (error_o)
  );

  os_builder builder_i (
    .req_i   (os_req),
    .words_o (os_words)
  );

  os_serializer serializer_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .start_i   (os_start),
    .words_i   (os_words),
    .user_i    (os_req.user),
    .m_ready_i (m_ready_i),
    .m_valid_o (m_valid_o),
    .m_beat_o  (m_beat_o),
    .done_o    (os_done)
  );

  config_timer timer_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .restart_i (timer_restart),
    .long_i    (timer_long),
    .expired_o (timer_expired)
  );

endmodule

// File: verilog/os_builder.sv
/* Purely combinational; idle sets are all zero whatever the rate. */
module os_builder (
  input  ltssm_cfg_pkg::os_request_t req_i,
  output ltssm_cfg_pkg::os_words_t   words_o
);

  ltssm_cfg_pkg::symbol_t [ltssm_cfg_pkg::SYMS_PER_OS-1:0] sym;

  always_comb begin
    sym = '0;
    if (req_i.kind != ltssm_cfg_pkg::OS_IDLE) begin
      sym[0] = ltssm_cfg_pkg::COM_SYMBOL;
      sym[1] = ltssm_cfg_pkg::LINK_NUM;
      // lane number goes to PAD until widths settle
      sym[2] = req_i.lane_pad ? ltssm_cfg_pkg::PAD_SYMBOL : '0;
      sym[3] = ltssm_cfg_pkg::N_FTS_DEFAULT;
      sym[4] = ltssm_cfg_pkg::RATE_ID_DEFAULT;
      sym[5] = '0;
      for (int i = 6; i < ltssm_cfg_pkg::SYMS_PER_OS; i++) begin
        if (req_i.kind == ltssm_cfg_pkg::OS_TS2) begin
          sym[i] = ltssm_cfg_pkg::TS2_ID;
        end else begin
          sym[i] = ltssm_cfg_pkg::TS1_ID;
        end
      end
    end
  end

  // symbol 0 lands in the low byte of word 0
  assign words_o = sym;

endmodule

// File: verilog/os_serializer.sv
/* Start only while idle; a start during a set is not queued.
   done_o pulses the cycle after the last beat is accepted. */
module os_serializer (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        start_i,
  input  ltssm_cfg_pkg::os_words_t    words_i,
  input  ltssm_cfg_pkg::user_t        user_i,
  input  logic                        m_ready_i,
  output logic                        m_valid_o,
  output ltssm_cfg_pkg::stream_beat_t m_beat_o,
  output logic                        done_o
);

  ltssm_cfg_pkg::os_words_t  words_q;
  ltssm_cfg_pkg::user_t      user_q;
  ltssm_cfg_pkg::beat_idx_t  idx_q;
  logic                      is_last;
  logic                      xfer;

  assign is_last = (idx_q == ltssm_cfg_pkg::beat_idx_t'(ltssm_cfg_pkg::BEATS_PER_OS - 1));
  assign xfer    = m_valid_o && m_ready_i;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      m_valid_o <= 1'b0;
      idx_q     <= '0;
      done_o    <= 1'b0;
    end else begin
      done_o <= xfer && is_last;
      if (start_i) begin
        m_valid_o <= 1'b1;
        idx_q     <= '0;
      end else if (xfer) begin
        if (is_last) begin
          m_valid_o <= 1'b0;
        end
        idx_q <= idx_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      words_q <= words_i;
      user_q  <= user_i;
    end
  end

  // all fields come from registers, so a stalled beat holds
  always_comb begin
    m_beat_o.data = words_q[idx_q];
    m_beat_o.user = user_q;
    m_beat_o.last = is_last;
  end

endmodule
